/* tb_program_input.txt */
// program words from 0x00010000 until ffffffff, then expected stores
// store columns: word address, data in strobed lanes, strobe; ffffffff ends
// alu and upper-immediate ops
00500093 FFD00113 002081B3 40208233
001112B3 00112333 001133B3 0020C433
001154B3 40115533 0020E5B3 0020F633
00710693 FFE12713 FFF13793 0F014813
0A00E893 7F017913 01C09993 01C15A13
40115A93 12345B37 00001B97 10302023
10402223 10502423 10602623 10702823
10802A23 10902C23 10A02E23 12B02023
12C02223 12D02423 12E02623 12F02823
13002A23 13102C23 13202E23 15302023
15402223 15502423 15602623 15702823
// forwarding
00100093 001080B3 001080B3 00308113
002081B3 20302023 20202223
// load-use
14C02203 00120293 30502023 10002303
30602223
// branches and jumps, stores to 0x4f0..0x4fc sit in flushed slots
00900393 00738663 4E702823 4E702A23
00739663 40702023 00714463 4E702C23
0023F463 4E702E23 00C0046F 4E702823
4E702A23 40802223 00000497 01048567
4E702823 4E702A23 40A02423
// byte and half, then spin
89ABC5B7 7EF58593 50B02023 50B002A3
50B01523 50500603 50504683 50A01703
50A05783 50C02623 50D02823 50E02A23
50F02C23 0000006F
FFFFFFFF
00000100 00000002 F
00000104 00000008 F
00000108 FFFFFFA0 F
0000010C 00000001 F
00000110 00000000 F
00000114 FFFFFFF8 F
00000118 07FFFFFF F
0000011C FFFFFFFF F
00000120 FFFFFFFD F
00000124 00000005 F
00000128 00000004 F
0000012C 00000001 F
00000130 00000001 F
00000134 FFFFFF0D F
00000138 000000A5 F
0000013C 000007F0 F
00000140 50000000 F
00000144 0000000F F
00000148 FFFFFFFE F
0000014C 12345000 F
00000150 00011058 F
00000200 0000000B F
00000204 00000007 F
00000300 12345001 F
00000304 00000002 F
00000400 00000009 F
00000404 0001010C F
00000408 00010120 F
00000500 89ABC7EF F
00000504 0000EF00 2
00000508 C7EF0000 C
0000050C FFFFFFEF F
00000510 000000EF F
00000514 FFFFC7EF F
00000518 0000C7EF F
FFFFFFFF

/* files.f */
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_pipe_if.sv
rv_alu.sv
rv_datapath.sv
rv_controller.sv
rv_hazard.sv
rv_core.sv
rv_core_chk.sv
tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - rv_isa_pkg.sv
  - rv_pipe_pkg.sv
  - rv_pipe_if.sv
  - rv_alu.sv
  - rv_datapath.sv
  - rv_controller.sv
  - rv_hazard.sv
  - rv_core.sv
  - target: test
    files:
      - rv_core_chk.sv
      - tb_rv_core.sv

/* tb_rv_core.sv */
// rv32i core testbench

`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module tb_rv_core
  import rv_isa_pkg::*;
;

  localparam int CLK_PERIOD = 100;
  localparam word_t TERM = 32'hffff_ffff;

  logic       clk;
  logic       i_rst;
  word_t      o_imem_addr, i_imem_data;
  word_t      o_dmem_addr, o_dmem_wdata, i_dmem_rdata;
  logic       o_dmem_we;
  logic [3:0] o_dmem_wstrb;

  word_t      file_words [0:255];
  word_t      imem [0:127];
  word_t      dmem [0:1023];
  word_t      imem_off;
  word_t      exp_addr [$];
  word_t      exp_data [$];
  logic [3:0] exp_strb [$];
  int         n_prog, n_exp, n_seen, errors, checks;
  int         grp_checks [0:7];
  int         grp_errs [0:7];
  word_t      fill_base;
  word_t      got_data;
  int         grp;
  logic       bad;

  rv_core UUT (
    .i_clock      (clk),
    .i_rst        (i_rst),
    .o_imem_addr  (o_imem_addr),
    .i_imem_data  (i_imem_data),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_we    (o_dmem_we),
    .o_dmem_wstrb (o_dmem_wstrb),
    .i_dmem_rdata (i_dmem_rdata)
  );

  // combinational memory reads
  assign imem_off     = o_imem_addr - `RV_RESET_PC;
  assign i_imem_data  = imem[imem_off[8:2]];
  assign i_dmem_rdata = dmem[o_dmem_addr[11:2]];

  // test group from the store address
  function automatic int store_group(input word_t addr);
    return int'(addr[10:8]);
  endfunction

  function automatic string test_name(input int g);
    case (g)
      1:       return "alu and upper-immediate results";
      2:       return "forwarding chains";
      3:       return "load-use stall";
      4:       return "branches and jumps";
      5:       return "byte and half accesses";
      default: return "unknown group";
    endcase
  endfunction

  function automatic word_t strobe_mask(input logic [3:0] s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // byte-wise data memory writes
  always @(posedge clk) begin
    if (o_dmem_we === 1'b1) begin
      for (int b = 0; b < 4; b++) begin
        if (o_dmem_wstrb[b]) begin
          dmem[o_dmem_addr[11:2]][b*8 +: 8] <= o_dmem_wdata[b*8 +: 8];
        end
      end
    end
  end

  // store monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (o_dmem_we === 1'b1) begin
      if (i_rst) begin
        errors++;
        $display("store seen during reset at %0t", $time);
      end else if (n_seen >= n_exp) begin
        errors++;
        $display("unexpected extra store to %h at %0t", o_dmem_addr, $time);
      end else begin
        grp      = store_group(exp_addr[n_seen]);
        got_data = o_dmem_wdata & strobe_mask(o_dmem_wstrb);
        bad      = 1'b0;
        checks++;
        if (o_dmem_addr !== exp_addr[n_seen]) begin
          $display("CHECK FAILED t=%0t o_dmem_addr got %h expected %h",
                   $time, o_dmem_addr, exp_addr[n_seen]);
          bad = 1'b1;
        end
        if (o_dmem_wstrb !== exp_strb[n_seen]) begin
          $display("CHECK FAILED t=%0t o_dmem_wstrb got %h expected %h",
                   $time, o_dmem_wstrb, exp_strb[n_seen]);
          bad = 1'b1;
        end
        if (got_data !== exp_data[n_seen]) begin
          $display("CHECK FAILED t=%0t o_dmem_wdata got %h expected %h",
                   $time, got_data, exp_data[n_seen]);
          bad = 1'b1;
        end
        grp_checks[grp]++;
        if (bad) begin
          errors++;
          grp_errs[grp]++;
        end
        // last record of its group ends that test
        if (n_seen + 1 == n_exp || store_group(exp_addr[n_seen + 1]) != grp) begin
          $display("test %0d %s: %0d stores, %0d errors", grp + 1, test_name(grp),
                   grp_checks[grp], grp_errs[grp]);
        end
        n_seen++;
      end
    end
  end

  initial begin
    int i;
    i_rst  = 1'b1;
    n_prog = 0;
    n_exp  = 0;
    n_seen = 0;
    errors = 0;
    checks = 0;
    for (int g = 0; g < 8; g++) begin
      grp_checks[g] = 0;
      grp_errs[g]   = 0;
    end
    fill_base = $urandom(32'h3b68);
    for (int a = 0; a < 1024; a++) begin
      dmem[a] = fill_base ^ (word_t'(a) * 32'h9e37_79b9);
    end
    // nops that carry their own index
    for (int a = 0; a < 128; a++) begin
      imem[a] = 32'h0000_0013 | (word_t'(a) << 20);
    end
    for (int a = 0; a < 256; a++) begin
      file_words[a] = TERM;
    end
    $readmemh("tb_program_input.txt", file_words);

    // program words, terminator, then address/data/strobe triples
    i = 0;
    while (i < 128 && file_words[i] != TERM) begin
      imem[i] = file_words[i];
      i++;
    end
    n_prog = i;
    i++;
    while (i + 2 < 256 && file_words[i] != TERM) begin
      exp_addr.push_back(file_words[i]);
      exp_data.push_back(file_words[i + 1]);
      exp_strb.push_back(file_words[i + 2][3:0]);
      i += 3;
    end
    n_exp = exp_addr.size();
    if (n_prog == 0 || n_exp == 0) begin
      errors++;
      $display("data file holds no program or no expected stores");
    end

    repeat (3) @(posedge clk);
    i_rst <= 1'b0;

    @(negedge clk);
    checks++;
    if (o_imem_addr !== `RV_RESET_PC) begin
      errors++;
      $display("CHECK FAILED t=%0t o_imem_addr got %h expected %h",
               $time, o_imem_addr, `RV_RESET_PC);
    end
    $display("test 1 reset and first fetch: done, %0d errors so far", errors);

    wait (n_seen >= n_exp);
    // flushed stores could still show up late
    repeat (20) @(negedge clk);

    $display("stores seen %0d of %0d, checks %0d, errors %0d", n_seen, n_exp, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // ten cycles per program word plus margin
  initial begin
    wait (n_prog > 0);
    #(CLK_PERIOD * (10 * n_prog + 100));
    $display("timeout: only %0d of %0d expected stores seen", n_seen, n_exp);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* rv_core_chk.sv */
// pipeline control assertions

`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_core_chk
  import rv_isa_pkg::*;
(
  input wire logic       i_clock,
  input wire logic       i_rst,
  input wire logic       i_dmem_we,
  input wire logic [3:0] i_dmem_wstrb,
  input wire word_t      i_imem_addr,
  input wire logic       i_f_stall,
  input wire logic       i_d_stall,
  input wire logic       i_e_flush,
  input wire logic       i_e_is_load
);

  a_no_write_in_reset: assert property (@(posedge i_clock)
    i_rst && $past(i_rst) |-> !i_dmem_we)
    else $error("data write during reset");

  a_strobe_with_write: assert property (@(posedge i_clock) disable iff (i_rst)
    (i_dmem_wstrb != 4'b0000) == i_dmem_we)
    else $error("strobe and write enable disagree");

  // a load-use stall inserts one execute bubble and lasts one cycle
  a_stall_flush: assert property (@(posedge i_clock) disable iff (i_rst)
    i_d_stall |-> i_e_flush ##1 (!i_e_is_load && !i_d_stall))
    else $error("load-use stall without a single execute bubble");

  a_pc_held: assert property (@(posedge i_clock) disable iff (i_rst)
    i_f_stall |=> $stable(i_imem_addr))
    else $error("fetch address moved during stall");

endmodule

bind rv_core rv_core_chk u_chk (
  .i_clock      (i_clock),
  .i_rst        (i_rst),
  .i_dmem_we    (o_dmem_we),
  .i_dmem_wstrb (o_dmem_wstrb),
  .i_imem_addr  (o_imem_addr),
  .i_f_stall    (haz_bus.f_stall),
  .i_d_stall    (haz_bus.d_stall),
  .i_e_flush    (haz_bus.e_flush),
  .i_e_is_load  (haz_bus.e_is_load)
);

`default_nettype wire

/* rv_core.sv */
// rv32i pipelined core

`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_core
  import rv_isa_pkg::*;
(
  input  wire logic  i_clock,
  input  wire logic  i_rst,
  output word_t      o_imem_addr,
  input  wire word_t i_imem_data,
  output word_t      o_dmem_addr,
  output word_t      o_dmem_wdata,
  output logic       o_dmem_we,
  output logic [3:0] o_dmem_wstrb,
  input  wire word_t i_dmem_rdata
);

  rv_ctrl_if   ctrl_bus ();
  rv_hazard_if haz_bus ();

  rv_datapath u_datapath (
    .i_clock      (i_clock),
    .i_rst        (i_rst),
    .ctrl         (ctrl_bus.dp),
    .hz           (haz_bus.dp),
    .o_imem_addr  (o_imem_addr),
    .i_imem_data  (i_imem_data),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_wstrb (o_dmem_wstrb),
    .i_dmem_rdata (i_dmem_rdata)
  );

  rv_controller u_controller (
    .i_clock   (i_clock),
    .i_rst     (i_rst),
    .ctrl      (ctrl_bus.ctrl),
    .hz        (haz_bus.ctrl),
    .o_dmem_we (o_dmem_we)
  );

  rv_hazard u_hazard (
    .hz (haz_bus.haz)
  );

endmodule

`default_nettype wire

/* rv_hazard.sv */
// forwarding, stall and flush logic

`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_hazard
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  rv_hazard_if.haz hz
);

  logic load_use;

  // memory stage wins over writeback
  function automatic fwd_sel_e pick_fwd(input reg_addr_t rs,
                                        input logic m_we, input reg_addr_t m_rd,
                                        input logic w_we, input reg_addr_t w_rd);
    if (m_we && m_rd != '0 && m_rd == rs) begin
      return FWD_MEM;
    end else if (w_we && w_rd != '0 && w_rd == rs) begin
      return FWD_WB;
    end
    return FWD_RF;
  endfunction

  assign hz.e_fwd_a = pick_fwd(hz.e_rs1, hz.m_reg_write, hz.m_rd, hz.w_reg_write, hz.w_rd);
  assign hz.e_fwd_b = pick_fwd(hz.e_rs2, hz.m_reg_write, hz.m_rd, hz.w_reg_write, hz.w_rd);

  // load result is not ready until writeback
  assign load_use = hz.e_is_load && hz.e_rd != '0 &&
                    (hz.e_rd == hz.d_rs1 || hz.e_rd == hz.d_rs2);

  assign hz.f_stall = load_use;
  assign hz.d_stall = load_use;
  // younger two instructions dropped on redirect
  assign hz.d_flush = hz.e_redirect;
  assign hz.e_flush = hz.e_redirect || load_use;

endmodule

`default_nettype wire

/* rv_controller.sv */
// decode and control pipeline

`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_controller
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  wire logic i_clock,
  input  wire logic i_rst,
  rv_ctrl_if.ctrl   ctrl,
  rv_hazard_if.ctrl hz,
  output logic      o_dmem_we
);

  opcode_e     opcode;
  logic [2:0]  funct3_d, funct3_e, funct3_m;
  logic        alt_d, alu_src_d, imm_plus_src_d, reg_write_d, mem_write_d, is_load_d;
  logic        branch_d, jal_d, jalr_d, taken_e;
  alu_op_e     alu_op_d;
  result_sel_e result_sel_d, result_sel_e_q;
  logic        reg_write_e, mem_write_e, branch_e, jal_e, jalr_e;
  logic        reg_write_m, mem_write_m, reg_write_w;
  pc_sel_e     pc_sel_e_q;

  // funct7 bit 30 picks sub and sra
  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode   = opcode_e'(ctrl.d_inst[6:0]);
  assign funct3_d = ctrl.d_inst[14:12];
  assign alt_d    = ctrl.d_inst[30];

  always_comb begin
    ctrl.d_imm_sel = IMM_I;
    alu_op_d       = ALU_ADD;
    alu_src_d      = 1'b1;
    imm_plus_src_d = 1'b0;
    reg_write_d    = 1'b0;
    mem_write_d    = 1'b0;
    is_load_d      = 1'b0;
    result_sel_d   = RES_ALU;
    branch_d       = 1'b0;
    jal_d          = 1'b0;
    jalr_d         = 1'b0;
    case (opcode)
      OPC_LUI: begin
        ctrl.d_imm_sel = IMM_U;
        alu_op_d       = ALU_PASSB;
        reg_write_d    = 1'b1;
        result_sel_d   = RES_IMM;
      end
      OPC_AUIPC: begin
        ctrl.d_imm_sel = IMM_U;
        imm_plus_src_d = 1'b1;
        reg_write_d    = 1'b1;
        result_sel_d   = RES_IMM;
      end
      OPC_JAL: begin
        ctrl.d_imm_sel = IMM_J;
        reg_write_d    = 1'b1;
        result_sel_d   = RES_PC4;
        jal_d          = 1'b1;
      end
      OPC_JALR: begin
        reg_write_d  = 1'b1;
        result_sel_d = RES_PC4;
        jalr_d       = 1'b1;
      end
      OPC_BRANCH: begin
        ctrl.d_imm_sel = IMM_B;
        alu_src_d      = 1'b0;
        alu_op_d       = ALU_SUB;
        branch_d       = 1'b1;
      end
      OPC_LOAD: begin
        reg_write_d  = 1'b1;
        is_load_d    = 1'b1;
        result_sel_d = RES_LOAD;
      end
      OPC_STORE: begin
        ctrl.d_imm_sel = IMM_S;
        mem_write_d    = 1'b1;
      end
      OPC_OP_IMM: begin
        // only srai carries the alternate bit
        alu_op_d    = alu_decode(funct3_d, alt_d && funct3_d == 3'b101);
        reg_write_d = 1'b1;
      end
      OPC_OP: begin
        alu_src_d   = 1'b0;
        alu_op_d    = alu_decode(funct3_d, alt_d);
        reg_write_d = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // execute stage, cleared on flush
  always_ff @(posedge i_clock) begin
    if (i_rst || hz.e_flush) begin
      reg_write_e  <= 1'b0;
      mem_write_e  <= 1'b0;
      hz.e_is_load <= 1'b0;
      branch_e     <= 1'b0;
      jal_e        <= 1'b0;
      jalr_e       <= 1'b0;
    end else begin
      reg_write_e  <= reg_write_d;
      mem_write_e  <= mem_write_d;
      hz.e_is_load <= is_load_d;
      branch_e     <= branch_d;
      jal_e        <= jal_d;
      jalr_e       <= jalr_d;
    end
  end

  always_ff @(posedge i_clock) begin
    ctrl.e_alu_op       <= alu_op_d;
    ctrl.e_alu_src      <= alu_src_d;
    ctrl.e_imm_plus_src <= imm_plus_src_d;
    result_sel_e_q      <= result_sel_d;
    funct3_e            <= funct3_d;
  end

  // branch resolution
  always_comb begin
    case (funct3_e)
      3'b000:  taken_e = ctrl.e_zero;
      3'b001:  taken_e = !ctrl.e_zero;
      3'b100:  taken_e = ctrl.e_lt;
      3'b101:  taken_e = !ctrl.e_lt;
      3'b110:  taken_e = ctrl.e_ltu;
      3'b111:  taken_e = !ctrl.e_ltu;
      default: taken_e = 1'b0;
    endcase
    if (jalr_e) begin
      pc_sel_e_q = PC_JALR;
    end else if (jal_e || (branch_e && taken_e)) begin
      pc_sel_e_q = PC_BRANCH;
    end else begin
      pc_sel_e_q = PC_PLUS4;
    end
  end

  assign ctrl.e_pc_sel = pc_sel_e_q;
  assign hz.e_redirect = (pc_sel_e_q != PC_PLUS4);

  // memory and writeback stages
  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      reg_write_m <= 1'b0;
      mem_write_m <= 1'b0;
      reg_write_w <= 1'b0;
    end else begin
      reg_write_m <= reg_write_e;
      mem_write_m <= mem_write_e;
      reg_write_w <= reg_write_m;
    end
  end

  always_ff @(posedge i_clock) begin
    ctrl.m_result_sel <= result_sel_e_q;
    funct3_m          <= funct3_e;
    ctrl.w_result_sel <= ctrl.m_result_sel;
  end

  assign ctrl.m_mem_write   = mem_write_m;
  assign ctrl.m_mem_size    = mem_size_e'(funct3_m[1:0]);
  assign ctrl.m_load_signed = !funct3_m[2];
  assign ctrl.w_reg_write   = reg_write_w;
  assign hz.m_reg_write     = reg_write_m;
  assign hz.w_reg_write     = reg_write_w;
  assign o_dmem_we          = mem_write_m;

endmodule

`default_nettype wire

/* rv_datapath.sv */
// five-stage rv32i datapath

`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_datapath
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  wire logic   i_clock,
  input  wire logic   i_rst,
  rv_ctrl_if.dp       ctrl,
  rv_hazard_if.dp     hz,
  output word_t       o_imem_addr,
  input  wire word_t  i_imem_data,
  output word_t       o_dmem_addr,
  output word_t       o_dmem_wdata,
  output logic [3:0]  o_dmem_wstrb,
  input  wire word_t  i_dmem_rdata
);

  word_t     pc_f, pc_plus4_f, pc_next_f;
  word_t     inst_d, pc_d, pc_plus4_d, rd1_d, rd2_d, imm_d, pc_plus_imm_d;
  word_t     rd1_e, rd2_e, imm_e, pc_plus_imm_e, pc_plus4_e;
  word_t     src_a_e, wdata_e, alu_b_e, alu_result_e, imm_plus_e;
  word_t     alu_m, wdata_m, imm_plus_m, pc_plus4_m, fwd_m, load_raw_m, load_m;
  word_t     fwd_w, load_w, result_w;
  reg_addr_t rd_w;
  logic [4:0] lane_shift;
  word_t     regs [`RV_NREGS];

  function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t rf,
                                    input word_t mem, input word_t wb);
    case (sel)
      FWD_MEM: return mem;
      FWD_WB:  return wb;
      default: return rf;
    endcase
  endfunction

  // fetch
  assign o_imem_addr = pc_f;
  assign pc_plus4_f  = pc_f + 32'd4;

  always_comb begin
    case (ctrl.e_pc_sel)
      PC_BRANCH: pc_next_f = pc_plus_imm_e;
      PC_JALR:   pc_next_f = {alu_result_e[`RV_XLEN-1:1], 1'b0};
      default:   pc_next_f = pc_plus4_f;
    endcase
  end

  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      pc_f <= `RV_RESET_PC;
    end else if (!hz.f_stall) begin
      pc_f <= pc_next_f;
    end
  end

  // decode register, a cleared word decodes as a bubble
  always_ff @(posedge i_clock) begin
    if (i_rst || hz.d_flush) begin
      inst_d <= '0;
    end else if (!hz.d_stall) begin
      inst_d <= i_imem_data;
    end
  end

  always_ff @(posedge i_clock) begin
    if (!hz.d_stall) begin
      pc_d       <= pc_f;
      pc_plus4_d <= pc_plus4_f;
    end
  end

  assign ctrl.d_inst = inst_d;
  assign hz.d_rs1    = inst_d[19:15];
  assign hz.d_rs2    = inst_d[24:20];

  // register file, write before read
  always_ff @(posedge i_clock) begin
    if (ctrl.w_reg_write && rd_w != '0) begin
      regs[rd_w] <= result_w;
    end
  end

  assign rd1_d = (hz.d_rs1 == '0) ? '0 :
                 (ctrl.w_reg_write && rd_w == hz.d_rs1) ? result_w : regs[hz.d_rs1];
  assign rd2_d = (hz.d_rs2 == '0) ? '0 :
                 (ctrl.w_reg_write && rd_w == hz.d_rs2) ? result_w : regs[hz.d_rs2];

  always_comb begin
    case (ctrl.d_imm_sel)
      IMM_S:   imm_d = {{20{inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
      IMM_B:   imm_d = {{20{inst_d[31]}}, inst_d[7], inst_d[30:25], inst_d[11:8], 1'b0};
      IMM_U:   imm_d = {inst_d[31:12], 12'b0};
      IMM_J:   imm_d = {{12{inst_d[31]}}, inst_d[19:12], inst_d[20], inst_d[30:21], 1'b0};
      default: imm_d = {{20{inst_d[31]}}, inst_d[31:20]};
    endcase
  end

  assign pc_plus_imm_d = pc_d + imm_d;

  // execute register
  always_ff @(posedge i_clock) begin
    if (i_rst || hz.e_flush) begin
      hz.e_rd  <= '0;
      hz.e_rs1 <= '0;
      hz.e_rs2 <= '0;
    end else begin
      hz.e_rd  <= inst_d[11:7];
      hz.e_rs1 <= hz.d_rs1;
      hz.e_rs2 <= hz.d_rs2;
    end
  end

  always_ff @(posedge i_clock) begin
    rd1_e         <= rd1_d;
    rd2_e         <= rd2_d;
    imm_e         <= imm_d;
    pc_plus_imm_e <= pc_plus_imm_d;
    pc_plus4_e    <= pc_plus4_d;
  end

  assign src_a_e    = fwd_mux(hz.e_fwd_a, rd1_e, fwd_m, result_w);
  assign wdata_e    = fwd_mux(hz.e_fwd_b, rd2_e, fwd_m, result_w);
  assign alu_b_e    = ctrl.e_alu_src ? imm_e : wdata_e;
  assign imm_plus_e = ctrl.e_imm_plus_src ? pc_plus_imm_e : imm_e;

  rv_alu u_alu (
    .i_op     (ctrl.e_alu_op),
    .i_a      (src_a_e),
    .i_b      (alu_b_e),
    .o_result (alu_result_e),
    .o_zero   (ctrl.e_zero),
    .o_lt     (ctrl.e_lt),
    .o_ltu    (ctrl.e_ltu)
  );

  // memory register
  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      hz.m_rd <= '0;
    end else begin
      hz.m_rd <= hz.e_rd;
    end
  end

  always_ff @(posedge i_clock) begin
    alu_m      <= alu_result_e;
    wdata_m    <= wdata_e;
    imm_plus_m <= imm_plus_e;
    pc_plus4_m <= pc_plus4_e;
  end

  // value this instruction will write back
  always_comb begin
    case (ctrl.m_result_sel)
      RES_IMM: fwd_m = imm_plus_m;
      RES_PC4: fwd_m = pc_plus4_m;
      default: fwd_m = alu_m;
    endcase
  end

  // byte lanes from the low address bits
  assign lane_shift   = {alu_m[1:0], 3'b000};
  assign o_dmem_addr  = {alu_m[`RV_XLEN-1:2], 2'b00};
  assign o_dmem_wdata = wdata_m << lane_shift;

  always_comb begin
    case (ctrl.m_mem_size)
      SIZE_BYTE: o_dmem_wstrb = 4'b0001 << alu_m[1:0];
      SIZE_HALF: o_dmem_wstrb = 4'b0011 << {alu_m[1], 1'b0};
      default:   o_dmem_wstrb = 4'b1111;
    endcase
    if (!ctrl.m_mem_write) begin
      o_dmem_wstrb = 4'b0000;
    end
  end

  assign load_raw_m = i_dmem_rdata >> lane_shift;

  always_comb begin
    case (ctrl.m_mem_size)
      SIZE_BYTE: load_m = {{24{ctrl.m_load_signed & load_raw_m[7]}}, load_raw_m[7:0]};
      SIZE_HALF: load_m = {{16{ctrl.m_load_signed & load_raw_m[15]}}, load_raw_m[15:0]};
      default:   load_m = i_dmem_rdata;
    endcase
  end

  // writeback register
  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      rd_w <= '0;
    end else begin
      rd_w <= hz.m_rd;
    end
  end

  always_ff @(posedge i_clock) begin
    fwd_w  <= fwd_m;
    load_w <= load_m;
  end

  assign hz.w_rd   = rd_w;
  assign result_w  = (ctrl.w_result_sel == RES_LOAD) ? load_w : fwd_w;

endmodule

`default_nettype wire

/* rv_alu.sv */
// integer alu

`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_alu
  import rv_isa_pkg::*;
(
  input  wire alu_op_e i_op,
  input  wire word_t   i_a,
  input  wire word_t   i_b,
  output word_t        o_result,
  output logic         o_zero,
  output logic         o_lt,
  output logic         o_ltu
);

  // compare flags feed both slt and branches
  assign o_lt  = $signed(i_a) < $signed(i_b);
  assign o_ltu = i_a < i_b;

  always_comb begin
    case (i_op)
      ALU_ADD:   o_result = i_a + i_b;
      ALU_SUB:   o_result = i_a - i_b;
      ALU_SLL:   o_result = i_a << i_b[4:0];
      ALU_SLT:   o_result = word_t'(o_lt);
      ALU_SLTU:  o_result = word_t'(o_ltu);
      ALU_XOR:   o_result = i_a ^ i_b;
      ALU_SRL:   o_result = i_a >> i_b[4:0];
      ALU_SRA:   o_result = $signed(i_a) >>> i_b[4:0];
      ALU_OR:    o_result = i_a | i_b;
      ALU_AND:   o_result = i_a & i_b;
      ALU_PASSB: o_result = i_b;
      default:   o_result = '0;
    endcase
  end

  assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

/* rv_pipe_if.sv */
// controller and hazard interfaces

`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

interface rv_ctrl_if import rv_isa_pkg::*, rv_pipe_pkg::*;;
  word_t       d_inst;
  imm_sel_e    d_imm_sel;
  alu_op_e     e_alu_op;
  logic        e_alu_src, e_imm_plus_src;
  pc_sel_e     e_pc_sel;
  logic        e_zero, e_lt, e_ltu;
  logic        m_mem_write, m_load_signed;
  mem_size_e   m_mem_size;
  // memory-stage source picks the forwarded value
  result_sel_e m_result_sel, w_result_sel;
  logic        w_reg_write;

  modport ctrl (input d_inst, e_zero, e_lt, e_ltu,
                output d_imm_sel, e_alu_op, e_alu_src, e_imm_plus_src, e_pc_sel,
                output m_mem_write, m_load_signed, m_mem_size, m_result_sel,
                output w_result_sel, w_reg_write);
  modport dp (output d_inst, e_zero, e_lt, e_ltu,
              input d_imm_sel, e_alu_op, e_alu_src, e_imm_plus_src, e_pc_sel,
              input m_mem_write, m_load_signed, m_mem_size, m_result_sel,
              input w_result_sel, w_reg_write);
endinterface

interface rv_hazard_if import rv_isa_pkg::*, rv_pipe_pkg::*;;
  reg_addr_t d_rs1, d_rs2, e_rs1, e_rs2, e_rd, m_rd, w_rd;
  logic      e_is_load, m_reg_write, w_reg_write, e_redirect;
  logic      f_stall, d_stall, d_flush, e_flush;
  fwd_sel_e  e_fwd_a, e_fwd_b;

  modport dp (output d_rs1, d_rs2, e_rs1, e_rs2, e_rd, m_rd, w_rd,
              input f_stall, d_stall, d_flush, e_flush, e_fwd_a, e_fwd_b);
  modport ctrl (output e_is_load, m_reg_write, w_reg_write, e_redirect, input e_flush);
  modport haz (input d_rs1, d_rs2, e_rs1, e_rs2, e_rd, m_rd, w_rd,
               input e_is_load, m_reg_write, w_reg_write, e_redirect,
               output f_stall, d_stall, d_flush, e_flush, e_fwd_a, e_fwd_b);
endinterface

`default_nettype wire

/* rv_pipe_pkg.sv */
// pipeline control types

`default_nettype none

`include "rv_defs.svh"

package rv_pipe_pkg;

  typedef enum logic [1:0] {
    PC_PLUS4, PC_BRANCH, PC_JALR
  } pc_sel_e;

  // imm covers both lui and auipc
  typedef enum logic [1:0] {
    RES_ALU, RES_LOAD, RES_IMM, RES_PC4
  } result_sel_e;

  typedef enum logic [1:0] {
    FWD_RF, FWD_MEM, FWD_WB
  } fwd_sel_e;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE, SIZE_HALF, SIZE_WORD
  } mem_size_e;

endpackage

`default_nettype wire

/* rv_isa_pkg.sv */
// rv32i instruction set types

`default_nettype none

`include "rv_defs.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  // major opcodes of the supported groups
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } imm_sel_e;

  // pass-b forwards operand b untouched
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
  } alu_op_e;

endpackage

`default_nettype wire

/* rv_defs.svh */
// rv32i core parameters

`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// integer data path width
`define RV_XLEN 32

// architectural registers x0..x31
`define RV_NREGS 32

// first fetch address out of reset
`define RV_RESET_PC 32'h0001_0000

`endif
